// ==== vlog.f ====
logic/axi_bridge_pkg.sv
logic/miss_req_if.sv
logic/miss_request_latch.sv
logic/burst_read_engine.sv
logic/burst_write_engine.sv
logic/refill_return.sv
logic/cache_axi_bridge.sv
bench/axi_mem_model.sv
bench/cache_axi_bridge_assertions.sv
bench/cache_axi_bridge_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"

test:
	verilator --binary --timing --assert -f vlog.f --top-module cache_axi_bridge_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vcache_axi_bridge_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== bench/cache_axi_bridge_tb.sv ====
`default_nettype none

module cache_axi_bridge_tb;
    import axi_bridge_pkg::*;

    localparam int num_tests   = 5;
    localparam int test_cycles = 2000;  // bound per test, two requests at most

    logic                 clk;
    logic                 reset;
    logic                 icache_re;
    addr_t                icache_raddr;
    line_t                icache_cacheline_new;
    logic                 icache_refresh;
    logic                 dcache_re;
    addr_t                dcache_raddr;
    line_t                dcache_cacheline_new;
    logic                 dcache_we;
    addr_t                dcache_waddr;
    line_t                dcache_cacheline_old;
    logic                 dcache_refresh;
    logic [axi_id_wd-1:0] arid;
    addr_t                araddr;
    logic                 arvalid;
    logic                 arready;
    word_t                rdata;
    logic                 rlast;
    logic                 rvalid;
    logic                 rready;
    addr_t                awaddr;
    logic                 awvalid;
    logic                 awready;
    word_t                wdata;
    logic                 wlast;
    logic                 wvalid;
    logic                 wready;
    logic                 bvalid;
    logic                 bready;

    word_t                ref_mem [addr_t];
    logic                 exp_i, exp_d, exp_dpulse;
    line_t                exp_iline, exp_dline;
    int                   icnt, dcnt, icyc, dcyc, cycle;
    logic [axi_id_wd-1:0] ar_ids [$];
    addr_t                ar_addrs [$];
    int                   tests, checks, errors, err_before;
    line_t                wline;

    cache_axi_bridge cache_axi_bridge_i (.*);
    axi_mem_model mem_i (.*);

    bind cache_axi_bridge cache_axi_bridge_assertions assertions_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // same fill rule as the memory model: (a * 0x9e3779b1) ^ 0x5a5aa5a5
    function automatic line_t expected_line(input addr_t base);
        line_t l;
        addr_t a;
        for (int k = 0; k < line_beats; k++) begin
            a = base + addr_t'(4 * k);
            if (ref_mem.exists(a)) l[k*word_wd +: word_wd] = ref_mem[a];
            else l[k*word_wd +: word_wd] = (a * 32'h9e3779b1) ^ 32'h5a5aa5a5;
        end
        return l;
    endfunction

    task automatic check(input string name, input line_t got, input line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == err_before) ? "pass" : "fail");
        err_before = errors;
    endtask

    // comparison of each refresh pulse, plus a log of read address handshakes
    always @(posedge clk) begin
        if (!reset) begin
            if (icache_refresh) begin
                icnt++;
                icyc = cycle;
                if (!exp_i) begin
                    errors++;
                    $display("icache_refresh pulsed without an instruction refill request");
                end else check("icache_cacheline_new", icache_cacheline_new, exp_iline);
            end
            if (dcache_refresh) begin
                dcnt++;
                dcyc = cycle;
                if (!exp_dpulse) begin
                    errors++;
                    $display("dcache_refresh pulsed without a data cache request");
                end else if (exp_d) check("dcache_cacheline_new", dcache_cacheline_new, exp_dline);
            end
            if (arvalid && arready) begin
                ar_ids.push_back(arid);
                ar_addrs.push_back(araddr);
            end
        end
        cycle++;
    end

    task automatic run_request(input logic ire, input addr_t ia, input logic dre,
                               input addr_t da, input logic dwe, input addr_t wa,
                               input line_t wl);
        exp_i      = ire;
        exp_d      = dre;
        exp_dpulse = dre | dwe;
        exp_iline  = expected_line(ia);
        exp_dline  = expected_line(da);
        icnt = 0;
        dcnt = 0;
        ar_ids.delete();
        ar_addrs.delete();
        icache_re            = ire;
        icache_raddr         = ia;
        dcache_re            = dre;
        dcache_raddr         = da;
        dcache_we            = dwe;
        dcache_waddr         = wa;
        dcache_cacheline_old = wl;
        do @(posedge clk); while (!(icache_refresh || dcache_refresh));
        #1;
        icache_re = 1'b0;
        dcache_re = 1'b0;
        dcache_we = 1'b0;
        if (dwe) begin
            for (int k = 0; k < line_beats; k++) begin
                ref_mem[wa + addr_t'(4 * k)] = wl[k*word_wd +: word_wd];
            end
        end
        repeat (3) @(posedge clk);
        #1;
        check("icache_refresh count", line_t'(icnt), line_t'(ire));
        check("dcache_refresh count", line_t'(dcnt), line_t'(dre | dwe));
        if (ar_ids.size() != int'(ire) + int'(dre)) begin
            errors++;
            $display("wrong number of read address handshakes: %0d", ar_ids.size());
        end
    endtask

    initial begin
        void'($urandom(75));
        reset = 1'b1;
        icache_re = 1'b0;
        icache_raddr = '0;
        dcache_re = 1'b0;
        dcache_raddr = '0;
        dcache_we = 1'b0;
        dcache_waddr = '0;
        dcache_cacheline_old = '0;
        exp_i = 1'b0;
        exp_d = 1'b0;
        exp_dpulse = 1'b0;
        {icnt, dcnt, icyc, dcyc, cycle, tests, checks, errors, err_before} = '0;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        repeat (20) begin
            @(posedge clk);
            check("arvalid", line_t'(arvalid), line_t'(0));
            check("rready", line_t'(rready), line_t'(0));
            check("awvalid", line_t'(awvalid), line_t'(0));
            check("wvalid", line_t'(wvalid), line_t'(0));
            check("bready", line_t'(bready), line_t'(0));
            check("refresh", line_t'(icache_refresh | dcache_refresh), line_t'(0));
        end
        #1;
        finish_test("idle after reset");

        run_request(1'b1, 32'h0000_1000, 1'b0, '0, 1'b0, '0, '0);
        if (ar_ids.size() == 1) check("arid", line_t'(ar_ids[0]), line_t'(icache_id));
        finish_test("instruction refill");

        run_request(1'b0, '0, 1'b1, 32'h0000_2040, 1'b0, '0, '0);
        if (ar_ids.size() == 1) check("arid", line_t'(ar_ids[0]), line_t'(dcache_id));
        finish_test("data refill");

        for (int k = 0; k < line_beats; k++) wline[k*word_wd +: word_wd] = $urandom;
        run_request(1'b0, '0, 1'b0, '0, 1'b1, 32'h0000_2000, wline);
        run_request(1'b0, '0, 1'b1, 32'h0000_2000, 1'b0, '0, '0);
        check("dcache_cacheline_new", dcache_cacheline_new, wline);
        finish_test("writeback then refill");

        for (int k = 0; k < line_beats; k++) wline[k*word_wd +: word_wd] = $urandom;
        run_request(1'b1, 32'h0000_4000, 1'b1, 32'h0000_2000, 1'b1, 32'h0000_3000, wline);
        check("refresh cycle", line_t'(dcyc), line_t'(icyc));
        if (ar_addrs.size() == 2) begin
            check("araddr first", line_t'(ar_addrs[0]), line_t'(32'h0000_4000));
            check("araddr second", line_t'(ar_addrs[1]), line_t'(32'h0000_2000));
            check("arid first", line_t'(ar_ids[0]), line_t'(icache_id));
            check("arid second", line_t'(ar_ids[1]), line_t'(dcache_id));
        end
        finish_test("combined request");

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(num_tests * test_cycles * 4);
        $display("timeout: the tests did not finish in the time allowed");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cache_axi_bridge_assertions.sv ====
`default_nettype none

module cache_axi_bridge_assertions (
    input wire logic                  clk,
    input wire logic                  reset,
    input wire logic                  arvalid,
    input wire logic                  arready,
    input wire axi_bridge_pkg::addr_t araddr,
    input wire logic                  awvalid,
    input wire logic                  awready,
    input wire axi_bridge_pkg::addr_t awaddr,
    input wire logic                  wvalid,
    input wire logic                  wready,
    input wire logic                  wlast,
    input wire logic                  icache_refresh,
    input wire logic                  dcache_refresh
);
    import axi_bridge_pkg::*;

    logic [4:0] w_count;  // write beats accepted in this burst

    always_ff @(posedge clk) begin
        if (reset) begin
            w_count <= '0;
        end else if (wvalid && wready) begin
            w_count <= wlast ? 5'd0 : w_count + 1'b1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before awready");

    wlast_on_last_beat: assert property (@(posedge clk) disable iff (reset)
        wlast == (wvalid && (w_count == 5'(line_beats - 1))))
        else $error("wlast not with wvalid on the last beat of the write burst");

    irefresh_pulse: assert property (@(posedge clk) disable iff (reset)
        icache_refresh |=> !icache_refresh)
        else $error("icache_refresh longer than one cycle");

    drefresh_pulse: assert property (@(posedge clk) disable iff (reset)
        dcache_refresh |=> !dcache_refresh)
        else $error("dcache_refresh longer than one cycle");

endmodule

`default_nettype wire

// ==== bench/axi_mem_model.sv ====
`default_nettype none

module axi_mem_model (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire axi_bridge_pkg::addr_t araddr,
    input  wire logic                  arvalid,
    output logic                       arready,
    output axi_bridge_pkg::word_t      rdata,
    output logic                       rlast,
    output logic                       rvalid,
    input  wire logic                  rready,
    input  wire axi_bridge_pkg::addr_t awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire axi_bridge_pkg::word_t wdata,
    input  wire logic                  wlast,
    input  wire logic                  wvalid,
    output logic                       wready,
    output logic                       bvalid,
    input  wire logic                  bready
);
    import axi_bridge_pkg::*;

    word_t mem [addr_t];
    logic  rd_active;
    addr_t rd_base;
    int    rd_beat;
    logic  aw_got;
    addr_t wr_base;
    int    wr_beat;
    logic  b_pend;

    // unwritten word at a reads as (a * 0x9e3779b1) ^ 0x5a5aa5a5
    function automatic word_t read_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return (a * 32'h9e3779b1) ^ 32'h5a5aa5a5;
    endfunction

    function automatic logic coin();
        return ($urandom % 4) != 0;  // ready or valid three times in four
    endfunction

    initial begin
        arready   = 1'b0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        rdata     = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        rd_active = 1'b0;
        rd_base   = '0;
        rd_beat   = 0;
        aw_got    = 1'b0;
        wr_base   = '0;
        wr_beat   = 0;
        b_pend    = 1'b0;
        forever begin
            @(posedge clk);
            if (reset) begin
                rd_active = 1'b0;
                aw_got    = 1'b0;
                b_pend    = 1'b0;
            end else begin
                if (arvalid && arready) begin
                    rd_active = 1'b1;
                    rd_base   = araddr;
                    rd_beat   = 0;
                end else if (rvalid && rready) begin
                    rd_beat++;
                    if (rd_beat == line_beats) rd_active = 1'b0;
                end
                if (awvalid && awready) begin
                    aw_got  = 1'b1;
                    wr_base = awaddr;
                    wr_beat = 0;
                end
                if (wvalid && wready) begin
                    mem[wr_base + addr_t'(4 * wr_beat)] = wdata;
                    wr_beat++;
                    if (wlast) begin  // burst ends where the master says
                        aw_got = 1'b0;
                        b_pend = 1'b1;
                    end
                end
                if (bvalid && bready) b_pend = 1'b0;
            end
            #1;
            arready = !rd_active && coin();
            rvalid  = rd_active && coin();
            rdata   = read_word(rd_base + addr_t'(4 * rd_beat));
            rlast   = rd_active && (rd_beat == line_beats - 1);
            awready = !aw_got && !b_pend && coin();
            wready  = aw_got && coin();
            bvalid  = b_pend && (bvalid || coin());  // holds once raised
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_axi_bridge.sv ====
`default_nettype none

module cache_axi_bridge (
    input  wire logic                            clk,
    input  wire logic                            reset,
    // icache side
    input  wire logic                            icache_re,
    input  wire axi_bridge_pkg::addr_t           icache_raddr,
    output axi_bridge_pkg::line_t                icache_cacheline_new,
    output logic                                 icache_refresh,
    // dcache side
    input  wire logic                            dcache_re,
    input  wire axi_bridge_pkg::addr_t           dcache_raddr,
    output axi_bridge_pkg::line_t                dcache_cacheline_new,
    input  wire logic                            dcache_we,
    input  wire axi_bridge_pkg::addr_t           dcache_waddr,
    input  wire axi_bridge_pkg::line_t           dcache_cacheline_old,
    output logic                                 dcache_refresh,
    // axi read
    output logic [axi_bridge_pkg::axi_id_wd-1:0] arid,
    output axi_bridge_pkg::addr_t                araddr,
    output logic                                 arvalid,
    input  wire logic                            arready,
    input  wire axi_bridge_pkg::word_t           rdata,
    input  wire logic                            rlast,
    input  wire logic                            rvalid,
    output logic                                 rready,
    // axi write
    output axi_bridge_pkg::addr_t                awaddr,
    output logic                                 awvalid,
    input  wire logic                            awready,
    output axi_bridge_pkg::word_t                wdata,
    output logic                                 wlast,
    output logic                                 wvalid,
    input  wire logic                            wready,
    input  wire logic                            bvalid,
    output logic                                 bready
);
    import axi_bridge_pkg::*;

    line_t icache_line;
    line_t dcache_line;
    logic  rd_done;
    logic  wr_done;
    logic  complete;

    miss_req_if req ();

    miss_request_latch latch_i (
        .clk                  (clk),
        .reset                (reset),
        .icache_re            (icache_re),
        .dcache_re            (dcache_re),
        .dcache_we            (dcache_we),
        .icache_raddr         (icache_raddr),
        .dcache_raddr         (dcache_raddr),
        .dcache_waddr         (dcache_waddr),
        .dcache_cacheline_old (dcache_cacheline_old),
        .complete             (complete),
        .req                  (req.latch)
    );

    burst_read_engine reader_i (
        .clk         (clk),
        .reset       (reset),
        .req         (req.reader),
        .arid        (arid),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready),
        .icache_line (icache_line),
        .dcache_line (dcache_line),
        .rd_done     (rd_done)
    );

    burst_write_engine writer_i (
        .clk     (clk),
        .reset   (reset),
        .req     (req.writer),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr_done (wr_done)
    );

    refill_return return_i (
        .clk                  (clk),
        .reset                (reset),
        .icache_rd            (req.icache_rd),
        .dcache_rd            (req.dcache_rd),
        .dcache_wb            (req.dcache_wb),
        .rd_done              (rd_done),
        .wr_done              (wr_done),
        .icache_line          (icache_line),
        .dcache_line          (dcache_line),
        .icache_cacheline_new (icache_cacheline_new),
        .dcache_cacheline_new (dcache_cacheline_new),
        .icache_refresh       (icache_refresh),
        .dcache_refresh       (dcache_refresh),
        .complete             (complete)
    );

endmodule

`default_nettype wire

// ==== logic/refill_return.sv ====
`default_nettype none

module refill_return (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  icache_rd,
    input  wire logic                  dcache_rd,
    input  wire logic                  dcache_wb,
    input  wire logic                  rd_done,
    input  wire logic                  wr_done,
    input  wire axi_bridge_pkg::line_t icache_line,
    input  wire axi_bridge_pkg::line_t dcache_line,
    output axi_bridge_pkg::line_t      icache_cacheline_new,
    output axi_bridge_pkg::line_t      dcache_cacheline_new,
    output logic                       icache_refresh,
    output logic                       dcache_refresh,
    output logic                       complete
);
    logic rd_seen;
    logic wr_seen;
    logic both_seen;

    assign both_seen = rd_seen && wr_seen;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_seen        <= 1'b0;
            wr_seen        <= 1'b0;
            icache_refresh <= 1'b0;
            dcache_refresh <= 1'b0;
            complete       <= 1'b0;
        end else begin
            icache_refresh <= 1'b0;
            dcache_refresh <= 1'b0;
            complete       <= 1'b0;
            if (both_seen) begin
                rd_seen        <= 1'b0;
                wr_seen        <= 1'b0;
                icache_refresh <= icache_rd;
                dcache_refresh <= dcache_rd | dcache_wb;  // writeback also finishes here
                complete       <= 1'b1;
            end else begin
                if (rd_done) rd_seen <= 1'b1;
                if (wr_done) wr_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (both_seen && icache_rd) begin
            icache_cacheline_new <= icache_line;
        end
        if (both_seen && dcache_rd) begin
            dcache_cacheline_new <= dcache_line;
        end
    end

endmodule

`default_nettype wire

// ==== logic/burst_write_engine.sv ====
`default_nettype none

module burst_write_engine (
    input  wire logic                  clk,
    input  wire logic                  reset,
    miss_req_if.writer                 req,
    output axi_bridge_pkg::addr_t      awaddr,
    output logic                       awvalid,
    input  wire logic                  awready,
    output axi_bridge_pkg::word_t      wdata,
    output logic                       wlast,
    output logic                       wvalid,
    input  wire logic                  wready,
    input  wire logic                  bvalid,
    output logic                       bready,
    output logic                       wr_done
);
    import axi_bridge_pkg::*;

    write_state_e state;
    beat_idx_t    beat;
    logic         last_beat;

    assign last_beat = (beat == beat_idx_t'(line_beats - 1));

    assign awvalid = (state == wr_addr);
    assign awaddr  = req.dcache_wb_addr;
    assign wvalid  = (state == wr_data);
    assign wdata   = req.dcache_wb_line[beat*word_wd +: word_wd];  // low beat first
    assign wlast   = wvalid && last_beat;
    assign bready  = (state == wr_resp);
    assign wr_done = (state == wr_finish);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= wr_idle;
            beat  <= '0;
        end else begin
            case (state)
                wr_idle: begin
                    if (req.start) begin
                        state <= req.dcache_wb ? wr_addr : wr_finish;
                    end
                end
                wr_addr: begin
                    if (awready) begin
                        state <= wr_data;
                        beat  <= '0;
                    end
                end
                wr_data: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= wr_resp;
                        end
                    end
                end
                wr_resp: begin
                    if (bvalid) begin
                        state <= wr_finish;
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/burst_read_engine.sv ====
`default_nettype none

module burst_read_engine (
    input  wire logic                            clk,
    input  wire logic                            reset,
    miss_req_if.reader                           req,
    output logic [axi_bridge_pkg::axi_id_wd-1:0] arid,
    output axi_bridge_pkg::addr_t                araddr,
    output logic                                 arvalid,
    input  wire logic                            arready,
    input  wire axi_bridge_pkg::word_t           rdata,
    input  wire logic                            rlast,
    input  wire logic                            rvalid,
    output logic                                 rready,
    output axi_bridge_pkg::line_t                icache_line,
    output axi_bridge_pkg::line_t                dcache_line,
    output logic                                 rd_done
);
    import axi_bridge_pkg::*;

    read_state_e state;
    beat_idx_t   beat;
    logic        beat_ok;

    assign arvalid = (state == icache_addr) || (state == dcache_addr);
    assign arid    = (state == icache_addr) ? icache_id : dcache_id;
    assign araddr  = (state == icache_addr) ? req.icache_rd_addr : req.dcache_rd_addr;
    assign rready  = (state == icache_data) || (state == dcache_data);
    assign rd_done = (state == rd_finish);
    assign beat_ok = rvalid && rready;  // beat taken this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= rd_idle;
            beat  <= '0;
        end else begin
            case (state)
                rd_idle: begin
                    if (req.start) begin
                        if (req.icache_rd) begin
                            state <= icache_addr;
                        end else if (req.dcache_rd) begin
                            state <= dcache_addr;
                        end else begin
                            state <= rd_finish;  // nothing to read
                        end
                    end
                end
                icache_addr: begin
                    if (arready) begin
                        state <= icache_data;
                        beat  <= '0;
                    end
                end
                icache_data: begin
                    if (beat_ok) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            state <= req.dcache_rd ? dcache_addr : rd_finish;
                        end
                    end
                end
                dcache_addr: begin
                    if (arready) begin
                        state <= dcache_data;
                        beat  <= '0;
                    end
                end
                dcache_data: begin
                    if (beat_ok) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            state <= rd_finish;
                        end
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // line assembly, one word per beat
    always_ff @(posedge clk) begin
        if (beat_ok && (state == icache_data)) begin
            icache_line[beat*word_wd +: word_wd] <= rdata;
        end
        if (beat_ok && (state == dcache_data)) begin
            dcache_line[beat*word_wd +: word_wd] <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/miss_request_latch.sv ====
`default_nettype none

module miss_request_latch (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  icache_re,
    input  wire logic                  dcache_re,
    input  wire logic                  dcache_we,
    input  wire axi_bridge_pkg::addr_t icache_raddr,
    input  wire axi_bridge_pkg::addr_t dcache_raddr,
    input  wire axi_bridge_pkg::addr_t dcache_waddr,
    input  wire axi_bridge_pkg::line_t dcache_cacheline_old,
    input  wire logic                  complete,
    miss_req_if.latch                  req
);
    import axi_bridge_pkg::*;

    latch_state_e state;
    logic         any_req;
    logic         take;

    assign any_req = icache_re | dcache_re | dcache_we;
    assign take    = (state == idle) && any_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= idle;
            req.start     <= 1'b0;
            req.icache_rd <= 1'b0;
            req.dcache_rd <= 1'b0;
            req.dcache_wb <= 1'b0;
        end else begin
            req.start <= 1'b0;
            case (state)
                idle: begin
                    if (any_req) begin
                        state         <= busy;
                        req.start     <= 1'b1;
                        req.icache_rd <= icache_re;
                        req.dcache_rd <= dcache_re;
                        req.dcache_wb <= dcache_we;
                    end
                end
                busy: begin
                    if (complete) begin
                        state <= drain;
                    end
                end
                default: state <= idle;  // skip the cycle the cache drops its level
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req.icache_rd_addr <= icache_raddr;
            req.dcache_rd_addr <= dcache_raddr;
            req.dcache_wb_addr <= dcache_waddr;
            req.dcache_wb_line <= dcache_cacheline_old;
        end
    end

endmodule

`default_nettype wire

// ==== logic/miss_req_if.sv ====
`default_nettype none

interface miss_req_if;
    import axi_bridge_pkg::*;

    logic  start;  // one cycle per new request
    logic  icache_rd;
    addr_t icache_rd_addr;
    logic  dcache_rd;
    addr_t dcache_rd_addr;
    logic  dcache_wb;
    addr_t dcache_wb_addr;
    line_t dcache_wb_line;

    modport latch (
        output start, icache_rd, icache_rd_addr, dcache_rd, dcache_rd_addr,
               dcache_wb, dcache_wb_addr, dcache_wb_line
    );

    modport reader (input start, icache_rd, icache_rd_addr, dcache_rd, dcache_rd_addr);

    modport writer (input start, dcache_wb, dcache_wb_addr, dcache_wb_line);

endinterface

`default_nettype wire

// ==== logic/axi_bridge_pkg.sv ====
`default_nettype none

package axi_bridge_pkg;

    localparam int addr_wd    = 32;
    localparam int word_wd    = 32;
    localparam int line_beats = 16;
    localparam int line_wd    = word_wd * line_beats;  // 512 bit line
    localparam int axi_id_wd  = 4;

    localparam logic [axi_id_wd-1:0] icache_id = 4'd0;
    localparam logic [axi_id_wd-1:0] dcache_id = 4'd1;

    typedef logic [addr_wd-1:0] addr_t;
    typedef logic [word_wd-1:0] word_t;
    typedef logic [line_wd-1:0] line_t;  // beat 0 in low word
    typedef logic [$clog2(line_beats)-1:0] beat_idx_t;

    typedef enum logic [1:0] {
        idle,
        busy,
        drain
    } latch_state_e;

    typedef enum logic [2:0] {
        rd_idle,
        icache_addr,
        icache_data,
        dcache_addr,
        dcache_data,
        rd_finish
    } read_state_e;

    typedef enum logic [2:0] {
        wr_idle,
        wr_addr,
        wr_data,
        wr_resp,
        wr_finish
    } write_state_e;

endpackage

`default_nettype wire
